// File: Makefile
SIM      = verilator
TOP      = pcie_loader_tb
FILELIST = pcie_loader.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported an error"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: pcie_loader.f
verilog/net_shape_pkg.sv
verilog/host_link_pkg.sv
verilog/host_rx_credit.sv
verilog/cmd_decoder.sv
verilog/value_packer.sv
verilog/ram_write_port.sv
verilog/pcie_loader_top.sv
sim/pcie_loader_assert.sv
sim/pcie_loader_tb.sv

// File: sim/pcie_loader_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_loader_assert #(
    parameter int CREDITS = 4
) (
    input wire clk,
    input wire pcieRst,
    input wire host_valid,
    input wire credit_return,
    input wire stall,
    input wire layer_we,
    input wire weight_we,
    input wire bias_we,
    input wire fm_done,
    input wire weight_done,
    input wire bias_done
);
    logic [7:0] in_flight;  // words taken whose credit has not come back

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + {7'd0, host_valid} - {7'd0, credit_return};
        end
    end

    // a credit pulse in flight already freed its FIFO slot
    a_credit_held: assert property (@(posedge clk) disable iff (pcieRst)
        host_valid |-> (in_flight < 8'(CREDITS) + {7'd0, credit_return}))
        else $error("host word sent while the ingress FIFO is full");

    a_one_write: assert property (@(posedge clk) disable iff (pcieRst)
        $onehot0({layer_we, weight_we, bias_we}))
        else $error("more than one RAM write strobe high in one cycle");

    a_fm_done: assert property (@(posedge clk) disable iff (pcieRst) fm_done |-> layer_we)
        else $error("fm_done without a layer RAM write");
    a_weight_done: assert property (@(posedge clk) disable iff (pcieRst)
        weight_done |-> weight_we)
        else $error("weight_done without a weight RAM write");
    a_bias_done: assert property (@(posedge clk) disable iff (pcieRst) bias_done |-> bias_we)
        else $error("bias_done without a bias RAM write");

    a_stall_hold: assert property (@(posedge clk) disable iff (pcieRst)
        $past(stall) |-> !(layer_we || weight_we || bias_we))
        else $error("write strobe right after a stall cycle");

endmodule

`default_nettype wire

// File: sim/pcie_loader_golden.mem
// tag(1) addr(5) data(8): 0 host word, 1 weight row run (addr = words, data = first value)
// 2 layer, 3 weight row (data = value count, first value), 4 bias write; tag+8 = done
00000004010003
000000deadbeef
00000012345678
000000a5a50f0f
0000005400200a
10000500000100
10000500000200
0000004c00400d
10000d00001000
0000004400803d
10003d00002000
00000094001003
000000ffff1234
0000000000abcd
0000005555beef
200100deadbeef
20010112345678
a00102a5a50f0f
30002000090100
b0002100090200
b0004000191000
b0008000792000
40001000001234
4000110000abcd
c000120000beef

// File: sim/pcie_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_loader_tb;
    import host_link_pkg::*;
    import net_shape_pkg::*;

    localparam int CREDITS    = 4;
    localparam int GOLD_DEPTH = 64;

    logic                     clk;
    logic                     pcieRst;
    logic                     host_valid;
    host_word_u               host_word;
    logic                     stall;
    logic                     credit_return;
    logic                     layer_we;
    logic [FM_ADDR_W-1:0]     layer_addr;
    logic [HOST_W-1:0]        layer_data;
    logic                     weight_we;
    logic [WEIGHT_ADDR_W-1:0] weight_addr;
    logic [WEIGHT_ROW_W-1:0]  weight_data;
    logic                     bias_we;
    logic [BIAS_ADDR_W-1:0]   bias_addr;
    logic [VALUE_W-1:0]       bias_data;
    logic                     fm_done;
    logic                     weight_done;
    logic                     bias_done;

    logic [55:0] gold [0:GOLD_DEPTH-1];     // tag, address field, data field
    logic [31:0] stim_q [$];
    logic [3:0]  exp_tag [$];
    logic [19:0] exp_addr [$];
    logic [31:0] exp_data [$];

    integer seed = 32'h85e8;
    int     credits;
    int     words_sent;
    int     credit_pulses;
    int     checked;
    int     cycles;
    int     limit;
    int     gold_lines;
    int     value_errors;
    int     other_errors;

    pcie_loader_top #(.CREDITS(CREDITS)) DUT (
        .clk(clk), .pcieRst(pcieRst), .host_valid(host_valid), .host_word(host_word),
        .stall(stall), .credit_return(credit_return),
        .layer_we(layer_we), .layer_addr(layer_addr), .layer_data(layer_data),
        .weight_we(weight_we), .weight_addr(weight_addr), .weight_data(weight_data),
        .bias_we(bias_we), .bias_addr(bias_addr), .bias_data(bias_data),
        .fm_done(fm_done), .weight_done(weight_done), .bias_done(bias_done)
    );

    bind pcie_loader_top pcie_loader_assert #(.CREDITS(CREDITS)) u_assert (
        .clk(clk), .pcieRst(pcieRst), .host_valid(host_valid),
        .credit_return(credit_return), .stall(stall),
        .layer_we(layer_we), .weight_we(weight_we), .bias_we(bias_we),
        .fm_done(fm_done), .weight_done(weight_done), .bias_done(bias_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // golden file parsing
    ////////////////////////////////////////////////////////////
    task automatic load_golden();
        logic [3:0]  tag;
        logic [31:0] data;
        int          n;
        for (int i = 0; i < GOLD_DEPTH; i++) begin
            gold[i] = {4'hf, 20'(i), 32'(i)};   // tag f ends the list
        end
        $readmemh("sim/pcie_loader_golden.mem", gold);
        for (int i = 0; i < GOLD_DEPTH; i++) begin
            tag  = gold[i][55:52];
            data = gold[i][31:0];
            if (tag == 4'hf) break;
            gold_lines++;
            if (tag == 4'h0) begin
                stim_q.push_back(data);
            end else if (tag == 4'h1) begin
                n = int'(gold[i][51:32]);
                // one weight row of consecutive values with the low half first
                for (int j = 0; j < n; j++) begin
                    stim_q.push_back({data[15:0] + 16'(2*j+1), data[15:0] + 16'(2*j)});
                end
            end else begin
                exp_tag.push_back(tag);
                exp_addr.push_back(gold[i][51:32]);
                exp_data.push_back(data);
            end
        end
    endtask

    // values in order from the first one with zeros above the matrix
    function automatic logic [WEIGHT_ROW_W-1:0] expected_row(logic [15:0] first, int count);
        logic [WEIGHT_ROW_W-1:0] row;
        row = '0;
        for (int k = 0; k < count; k++) begin
            row[k*VALUE_W +: VALUE_W] = first + 16'(k);
        end
        return row;
    endfunction

    task automatic compare_field(input string name, input logic [WEIGHT_ROW_W-1:0] expected,
                                 input logic [WEIGHT_ROW_W-1:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_write();
        logic [3:0]  tag;
        logic [19:0] addr;
        logic [31:0] data;
        logic        done_exp;
        if (checked >= exp_tag.size()) begin
            $display("RAM write at %0t ns with no expected write left", $time);
            other_errors++;
            return;
        end
        tag      = exp_tag[checked];
        addr     = exp_addr[checked];
        data     = exp_data[checked];
        done_exp = tag[3];
        checked++;
        if (tag[2:0] == 3'd2 && layer_we) begin
            compare_field("layer_addr", WEIGHT_ROW_W'(addr[FM_ADDR_W-1:0]),
                          WEIGHT_ROW_W'(layer_addr));
            compare_field("layer_data", WEIGHT_ROW_W'(data), WEIGHT_ROW_W'(layer_data));
            compare_field("fm_done", WEIGHT_ROW_W'(done_exp), WEIGHT_ROW_W'(fm_done));
        end else if (tag[2:0] == 3'd3 && weight_we) begin
            compare_field("weight_addr", WEIGHT_ROW_W'(addr[WEIGHT_ADDR_W-1:0]),
                          WEIGHT_ROW_W'(weight_addr));
            compare_field("weight_data", expected_row(data[15:0], int'(data[31:16])),
                          weight_data);
            compare_field("weight_done", WEIGHT_ROW_W'(done_exp), WEIGHT_ROW_W'(weight_done));
        end else if (tag[2:0] == 3'd4 && bias_we) begin
            compare_field("bias_addr", WEIGHT_ROW_W'(addr[BIAS_ADDR_W-1:0]),
                          WEIGHT_ROW_W'(bias_addr));
            compare_field("bias_data", WEIGHT_ROW_W'(data[15:0]), WEIGHT_ROW_W'(bias_data));
            compare_field("bias_done", WEIGHT_ROW_W'(done_exp), WEIGHT_ROW_W'(bias_done));
        end else begin
            $display("write at %0t ns went to the wrong RAM (expected record %0d)",
                     $time, checked - 1);
            other_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor sampled mid cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (credit_return) credit_pulses++;
        if (words_sent == 0 && (credit_return || layer_we || weight_we || bias_we ||
                                fm_done || weight_done || bias_done)) begin
            $display("output activity at %0t ns before any host word was sent", $time);
            other_errors++;
        end
        if (layer_we || weight_we || bias_we) begin
            if (!$onehot0({layer_we, weight_we, bias_we})) begin
                $display("more than one RAM written at %0t ns", $time);
                other_errors++;
            end
            check_write();
        end else if (fm_done || weight_done || bias_done) begin
            $display("done pulse without a RAM write at %0t ns", $time);
            other_errors++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d of %0d writes seen",
                     cycles, checked, exp_tag.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        pcieRst       = 1'b1;
        host_valid    = 1'b0;
        host_word     = '0;
        stall         = 1'b0;
        credits       = CREDITS;
        words_sent    = 0;
        credit_pulses = 0;
        checked       = 0;
        cycles        = 0;
        gold_lines    = 0;
        value_errors  = 0;
        other_errors  = 0;
        load_golden();
        limit = 20 * gold_lines + 100;
        repeat (2) @(posedge clk);
        #1 pcieRst = 1'b0;
        repeat (3) @(posedge clk);  // idle window where nothing may move
        while (stim_q.size() > 0) begin
            @(posedge clk);
            #1;
            if (credit_return) credits++;
            stall      = (($random(seed) & 3) == 0);
            host_valid = 1'b0;
            if (credits > 0 && ($random(seed) & 3) != 0) begin
                host_word  = stim_q.pop_front();
                host_valid = 1'b1;
                credits--;
                words_sent++;
            end
        end
        while (checked < exp_tag.size()) begin
            @(posedge clk);
            #1;
            host_valid = 1'b0;
            stall      = (($random(seed) & 3) == 0);
        end
        repeat (4) @(posedge clk);
        if (credit_pulses != words_sent) begin
            $display("%0d credit pulses returned for %0d host words", credit_pulses, words_sent);
            other_errors++;
        end
        $display("errors: %0d value, %0d other; %0d of %0d writes checked",
                 value_errors, other_errors, checked, exp_tag.size());
        if (value_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  wire                                  clk,
    input  wire                                  pcieRst,
    input  wire                                  in_valid,
    input  wire host_link_pkg::host_word_u       in_word,
    input  wire                                  out_ready,
    output logic                                 in_ready,
    output logic                                 out_valid,
    output host_link_pkg::cmd_kind_t             out_kind,
    output net_shape_pkg::layer_id_t             out_layer,
    output logic [net_shape_pkg::FM_ADDR_W-1:0]  out_base,
    output logic [host_link_pkg::HOST_W-1:0]     out_data,
    output logic                                 out_last
);
    import host_link_pkg::*;
    import net_shape_pkg::*;

    logic [HDR_COUNT_W-1:0] remain;     // zero means a header is due
    cmd_kind_t              cur_kind;
    layer_id_t              cur_layer;
    logic [FM_ADDR_W-1:0]   cur_base;
    logic                   take;

    assign in_ready = out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            remain    <= '0;
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid && (remain != '0);  // headers make no item
            if (take) begin
                remain <= (remain == '0) ? in_word.hdr.count : remain - 1'b1;
            end
        end
    end

    // command fields latched from the header, copied onto every payload word
    always_ff @(posedge clk) begin
        if (take) begin
            if (remain == '0) begin
                cur_kind  <= in_word.hdr.kind;
                cur_layer <= layer_id_t'(in_word.hdr.layer);
                cur_base  <= in_word.hdr.base;
            end else begin
                out_kind  <= cur_kind;
                out_layer <= cur_layer;
                out_base  <= cur_base;
                out_data  <= {in_word.data.hi, in_word.data.lo};
                out_last  <= (remain == HDR_COUNT_W'(1));
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/host_link_pkg.sv
`default_nettype none

package host_link_pkg;

    parameter int HOST_W      = 32;
    parameter int HDR_LAYER_W = 4;
    parameter int HDR_BASE_W  = 18;
    parameter int HDR_COUNT_W = 8;

    typedef enum logic [1:0] {
        LOAD_FM     = 2'd0,
        LOAD_WEIGHT = 2'd1,
        LOAD_BIAS   = 2'd2
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t              kind;
        logic [HDR_LAYER_W-1:0] layer;
        logic [HDR_BASE_W-1:0]  base;   // first RAM address of the command
        logic [HDR_COUNT_W-1:0] count;  // payload words that follow
    } hdr_view_t;

    typedef struct packed {
        logic [HOST_W/2-1:0] hi;
        logic [HOST_W/2-1:0] lo;        // sent first within a weight row
    } data_view_t;

    // one host word, header or payload depending on stream position
    typedef union packed {
        hdr_view_t  hdr;
        data_view_t data;
    } host_word_u;

endpackage

`default_nettype wire

// File: verilog/host_rx_credit.sv
`timescale 1ns/1ps
`default_nettype none

module host_rx_credit #(
    parameter int CREDITS = 4
) (
    input  wire                        clk,
    input  wire                        pcieRst,
    input  wire                        host_valid,
    input  wire host_link_pkg::host_word_u host_word,
    input  wire                        out_ready,
    output logic                       out_valid,
    output host_link_pkg::host_word_u  out_word,
    output logic                       credit_return
);
    import host_link_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

    host_word_u       mem [0:CREDITS-1];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   fill;
    logic             push;
    logic             pop;

    assign push      = host_valid && (fill != (PTR_W+1)'(CREDITS)); // host holds a credit anyway
    assign out_valid = (fill != '0);
    assign pop       = out_valid && out_ready;
    assign out_word  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= host_word;
        end
    end

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            fill          <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;   // one credit back per popped word
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/net_shape_pkg.sv
`default_nettype none

package net_shape_pkg;

    // layer codes keep the accelerator's numbering, pool and fc slots unused here
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        CONV1 = 4'd1,
        CONV2 = 4'd3,
        CONV3 = 4'd5,
        CONV4 = 4'd6,
        CONV5 = 4'd7
    } layer_id_t;

    parameter int MAX_MATRIX    = 121;              // 11x11 kernel of conv1
    parameter int VALUE_W       = 16;               // fixed point value
    parameter int WEIGHT_ROW_W  = MAX_MATRIX * VALUE_W;
    parameter int FM_ADDR_W     = 18;
    parameter int WEIGHT_ADDR_W = 10;
    parameter int BIAS_ADDR_W   = 9;

    // values per kernel matrix
    function automatic logic [6:0] matrix_size(input layer_id_t layer);
        case (layer)
            CONV1:               return 7'd121;
            CONV2:               return 7'd25;
            CONV3, CONV4, CONV5: return 7'd9;
            default:             return 7'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/pcie_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_loader_top #(
    parameter int CREDITS = 4
) (
    input  wire                                     clk,
    input  wire                                     pcieRst,
    input  wire                                     host_valid,
    input  wire host_link_pkg::host_word_u          host_word,
    input  wire                                     stall,
    output logic                                    credit_return,
    output logic                                    layer_we,
    output logic [net_shape_pkg::FM_ADDR_W-1:0]     layer_addr,
    output logic [host_link_pkg::HOST_W-1:0]        layer_data,
    output logic                                    weight_we,
    output logic [net_shape_pkg::WEIGHT_ADDR_W-1:0] weight_addr,
    output logic [net_shape_pkg::WEIGHT_ROW_W-1:0]  weight_data,
    output logic                                    bias_we,
    output logic [net_shape_pkg::BIAS_ADDR_W-1:0]   bias_addr,
    output logic [net_shape_pkg::VALUE_W-1:0]       bias_data,
    output logic                                    fm_done,
    output logic                                    weight_done,
    output logic                                    bias_done
);
    import host_link_pkg::*;
    import net_shape_pkg::*;

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////
    logic                    rx_valid, rx_ready;
    host_word_u              rx_word;
    logic                    dec_valid, dec_ready, dec_last;
    cmd_kind_t               dec_kind;
    layer_id_t               dec_layer;
    logic [FM_ADDR_W-1:0]    dec_base;
    logic [HOST_W-1:0]       dec_data;
    logic                    pk_valid, pk_ready, pk_last;
    cmd_kind_t               pk_kind;
    logic [FM_ADDR_W-1:0]    pk_base;
    logic [WEIGHT_ROW_W-1:0] pk_row;

    host_rx_credit #(.CREDITS(CREDITS)) u_rx (
        .clk(clk), .pcieRst(pcieRst),
        .host_valid(host_valid), .host_word(host_word),
        .out_ready(rx_ready), .out_valid(rx_valid), .out_word(rx_word),
        .credit_return(credit_return)
    );

    cmd_decoder u_dec (
        .clk(clk), .pcieRst(pcieRst),
        .in_valid(rx_valid), .in_word(rx_word), .out_ready(dec_ready),
        .in_ready(rx_ready), .out_valid(dec_valid), .out_kind(dec_kind),
        .out_layer(dec_layer), .out_base(dec_base), .out_data(dec_data),
        .out_last(dec_last)
    );

    value_packer u_pack (
        .clk(clk), .pcieRst(pcieRst),
        .in_valid(dec_valid), .in_kind(dec_kind), .in_layer(dec_layer),
        .in_base(dec_base), .in_data(dec_data), .in_last(dec_last),
        .out_ready(pk_ready), .in_ready(dec_ready), .out_valid(pk_valid),
        .out_kind(pk_kind), .out_base(pk_base), .out_row(pk_row), .out_last(pk_last)
    );

    ram_write_port u_wr (
        .clk(clk), .pcieRst(pcieRst), .stall(stall),
        .in_valid(pk_valid), .in_kind(pk_kind), .in_base(pk_base),
        .in_row(pk_row), .in_last(pk_last), .in_ready(pk_ready),
        .layer_we(layer_we), .layer_addr(layer_addr), .layer_data(layer_data),
        .weight_we(weight_we), .weight_addr(weight_addr), .weight_data(weight_data),
        .bias_we(bias_we), .bias_addr(bias_addr), .bias_data(bias_data),
        .fm_done(fm_done), .weight_done(weight_done), .bias_done(bias_done)
    );

endmodule

`default_nettype wire

// File: verilog/ram_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module ram_write_port (
    input  wire                                     clk,
    input  wire                                     pcieRst,
    input  wire                                     stall,
    input  wire                                     in_valid,
    input  wire host_link_pkg::cmd_kind_t           in_kind,
    input  wire [net_shape_pkg::FM_ADDR_W-1:0]      in_base,
    input  wire [net_shape_pkg::WEIGHT_ROW_W-1:0]   in_row,
    input  wire                                     in_last,
    output logic                                    in_ready,
    output logic                                    layer_we,
    output logic [net_shape_pkg::FM_ADDR_W-1:0]     layer_addr,
    output logic [host_link_pkg::HOST_W-1:0]        layer_data,
    output logic                                    weight_we,
    output logic [net_shape_pkg::WEIGHT_ADDR_W-1:0] weight_addr,
    output logic [net_shape_pkg::WEIGHT_ROW_W-1:0]  weight_data,
    output logic                                    bias_we,
    output logic [net_shape_pkg::BIAS_ADDR_W-1:0]   bias_addr,
    output logic [net_shape_pkg::VALUE_W-1:0]       bias_data,
    output logic                                    fm_done,
    output logic                                    weight_done,
    output logic                                    bias_done
);
    import host_link_pkg::*;
    import net_shape_pkg::*;

    logic [FM_ADDR_W-1:0] offset;   // items written so far in this command
    logic [FM_ADDR_W-1:0] addr;
    logic                 take;

    assign in_ready = !stall;
    assign take     = in_valid && in_ready;
    assign addr     = in_base + offset;

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            offset      <= '0;
            layer_we    <= 1'b0;
            weight_we   <= 1'b0;
            bias_we     <= 1'b0;
            fm_done     <= 1'b0;
            weight_done <= 1'b0;
            bias_done   <= 1'b0;
        end else begin
            layer_we    <= take && (in_kind == LOAD_FM);
            weight_we   <= take && (in_kind == LOAD_WEIGHT);
            bias_we     <= take && (in_kind == LOAD_BIAS);
            fm_done     <= take && in_last && (in_kind == LOAD_FM);
            weight_done <= take && in_last && (in_kind == LOAD_WEIGHT);
            bias_done   <= take && in_last && (in_kind == LOAD_BIAS);
            if (take) begin
                offset <= in_last ? '0 : offset + 1'b1;    // restart for next command
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            layer_addr  <= addr;
            layer_data  <= in_row[HOST_W-1:0];
            weight_addr <= addr[WEIGHT_ADDR_W-1:0];
            weight_data <= in_row;
            bias_addr   <= addr[BIAS_ADDR_W-1:0];
            bias_data   <= in_row[VALUE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/value_packer.sv
`timescale 1ns/1ps
`default_nettype none

module value_packer (
    input  wire                                    clk,
    input  wire                                    pcieRst,
    input  wire                                    in_valid,
    input  wire host_link_pkg::cmd_kind_t          in_kind,
    input  wire net_shape_pkg::layer_id_t          in_layer,
    input  wire [net_shape_pkg::FM_ADDR_W-1:0]     in_base,
    input  wire [host_link_pkg::HOST_W-1:0]        in_data,
    input  wire                                    in_last,
    input  wire                                    out_ready,
    output logic                                   in_ready,
    output logic                                   out_valid,
    output host_link_pkg::cmd_kind_t               out_kind,
    output logic [net_shape_pkg::FM_ADDR_W-1:0]    out_base,
    output logic [net_shape_pkg::WEIGHT_ROW_W-1:0] out_row,
    output logic                                   out_last
);
    import host_link_pkg::*;
    import net_shape_pkg::*;

    logic [WEIGHT_ROW_W-1:0] row_acc;
    logic [WEIGHT_ROW_W-1:0] next_row;
    logic [6:0]              vcnt;      // values already placed in the row
    logic [6:0]              msize;
    logic                    is_weight;
    logic                    row_done;
    logic                    take;

    assign in_ready  = out_ready;
    assign take      = in_valid && in_ready;
    assign is_weight = (in_kind == LOAD_WEIGHT);
    assign msize     = matrix_size(in_layer);
    assign row_done  = ({1'b0, vcnt} + 8'd2) >= {1'b0, msize};

    ////////////////////////////////////////////////////////////
    // weight row assembly, low value lands first
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_row = (vcnt == '0) ? '0 : row_acc;     // zeros above the matrix
        next_row[vcnt*VALUE_W +: VALUE_W] = in_data[VALUE_W-1:0];
        if (({1'b0, vcnt} + 8'd1) < {1'b0, msize}) begin
            next_row[(vcnt+1)*VALUE_W +: VALUE_W] = in_data[2*VALUE_W-1:VALUE_W];
        end
    end

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            vcnt      <= '0;
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid && (!is_weight || row_done);
            if (take && is_weight) begin
                vcnt <= row_done ? '0 : vcnt + 7'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_kind <= in_kind;
            out_base <= in_base;
            out_last <= in_last;    // last word always closes the last row
            if (is_weight) begin
                row_acc <= next_row;
                out_row <= next_row;
            end else begin
                out_row <= WEIGHT_ROW_W'(in_data);  // fm and bias pass through
            end
        end
    end

endmodule

`default_nettype wire
